// ==== sim.f ====
+incdir+include
hw/audio_pkg.sv
hw/env_pkg.sv
hw/exp_shift_sp_rom.sv
hw/pipe_delay.sv
hw/exp_shift.sv
hw/att_ramp.sv
hw/gain_mult.sv
hw/exp_gain_top.sv
tb/exp_gain_assertions.sv
tb/exp_gain_tb.sv

// ==== Makefile ====
TOP  := exp_gain_tb
SRCS := $(shell grep -v '^+' sim.f) include/exp_gain_defs.svh

.PHONY: all run clean

all: run

obj_dir/V$(TOP): sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/exp_gain_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exp_gain_defs.svh"

module exp_gain_tb
    import audio_pkg::*, env_pkg::*;
;

    logic           clk;
    logic           rst_n;
    sample_strobe_t sample_in;
    att_cmd_t       att_cmd;
    sample_strobe_t sample_out;

    gain_t   ref_table [256];
    sample_t exp_q [$];
    gain_t   gain_q [$];
    att_t    model_cur;
    att_t    model_target;
    att_t    model_rate;
    string   test_name;

    exp_gain_top exp_gain_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample_in  (sample_in),
        .att_cmd    (att_cmd),
        .sample_out (sample_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic compare_sample(input sample_t exp, input sample_t act);
        if (exp !== act)
        begin
            fail_run($sformatf("[FAIL] %s: expected %0d, actual %0d", test_name, exp, act));
        end
    endtask

    task automatic compare_gain(input gain_t exp, input gain_t act);
        if (exp !== act)
        begin
            fail_run($sformatf("[FAIL] %s: expected gain %0d, actual gain %0d",
                               test_name, exp, act));
        end
    endtask

    // gain = table[frac] >> octaves
    function automatic gain_t expected_gain(input att_t a);
        return ref_table[a[7:0]] >> a[11:8];
    endfunction

    function automatic sample_t expected_out(input sample_t s, input gain_t g);
        longint p;
        p = longint'(s) * longint'(g) + 64'sd16384;
        return sample_t'(p >>> 15);
    endfunction

    function automatic att_t ramp_step(input att_t cur, input att_t tgt, input att_t rate);
        int diff;
        diff = int'(tgt) - int'(cur);
        if (diff > int'(rate))
            return cur + rate;
        if (diff < -int'(rate))
            return cur - rate;
        return tgt;
    endfunction

    // one cycle of stimulus with the model kept in step
    task automatic drive(input logic cmd_v, input att_t tgt, input att_t rt,
                         input logic smp_v, input sample_t smp);
        gain_t g;
        @(posedge clk);
        att_cmd   <= '{valid: cmd_v, target: tgt, rate: rt};
        sample_in <= '{valid: smp_v, data: smp};
        if (smp_v)
        begin
            g = expected_gain(model_cur);
            gain_q.push_back(g);
            exp_q.push_back(expected_out(smp, g));
        end
        if (cmd_v)
        begin
            model_target = tgt;
            model_rate   = rt;
            if (rt == '0)
                model_cur = tgt;
        end
        else if (smp_v)
        begin
            model_cur = ramp_step(model_cur, model_target, model_rate);
        end
    endtask

    task automatic idle();
        drive(1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic send_sample(input sample_t s);
        drive(1'b0, '0, '0, 1'b1, s);
    endtask

    task automatic load_ramp(input att_t tgt, input att_t rt);
        drive(1'b1, tgt, rt, 1'b0, '0);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || gain_q.size() != 0)
        begin
            idle();
            cycles++;
            if (cycles > 50)
                fail_run($sformatf("%s: outputs did not drain within 50 cycles", test_name));
        end
        repeat (4) idle();
    endtask

    // outputs sampled at mid-cycle
    always @(negedge clk)
    begin
        if (rst_n && exp_gain_top_inst.exp_shift_inst.gain_valid)
        begin
            if (gain_q.size() == 0)
                fail_run($sformatf("%s: gain valid with no sample in flight", test_name));
            else
                compare_gain(gain_q.pop_front(), exp_gain_top_inst.exp_shift_inst.gain);
        end
        if (rst_n && sample_out.valid)
        begin
            if (exp_q.size() == 0)
                fail_run($sformatf("%s: output valid with no sample in flight", test_name));
            else
                compare_sample(exp_q.pop_front(), sample_out.data);
        end
    end

    task automatic reset_silence();
        test_name = "reset_silence";
        repeat (20) idle();
        send_sample(16'sh7fff);
        send_sample(-16'sh8000);
        idle();
        send_sample(16'sh7fff);
        wait_drain();
    endtask

    task automatic table_sweep();
        test_name = "table_sweep";
        for (int f = 0; f < 256; f++)
        begin
            load_ramp(att_t'(f), '0);
            send_sample(16'sh7fff);
        end
        wait_drain();
    endtask

    task automatic octave_shifts();
        sample_t s;
        test_name = "octave_shifts";
        for (int sh = 1; sh < 16; sh++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                s = (k == 0) ? -16'sh8000 : (k == 1) ? 16'sh7fff : sample_t'($urandom);
                load_ramp({4'(sh), 8'($urandom)}, '0);
                send_sample(s);
            end
        end
        wait_drain();
    endtask

    task automatic back_to_back_stream();
        test_name = "stream";
        load_ramp(att_t'($urandom_range(0, 2047)), '0);
        for (int i = 0; i < 200; i++)
            send_sample(sample_t'($urandom));
        wait_drain();
    endtask

    task automatic ramp_sequence();
        test_name = "ramp";
        load_ramp(12'h800, '0);
        load_ramp(12'h300, 12'h090);
        repeat (4)
        begin
            send_sample(sample_t'($urandom));
            idle();
            idle();
        end
        // retarget upward before reaching 0x300
        load_ramp(12'ha00, 12'h070);
        repeat (3) send_sample(sample_t'($urandom));
        // command and sample in the same cycle
        drive(1'b1, 12'h100, 12'h180, 1'b1, sample_t'($urandom));
        repeat (10) send_sample(sample_t'($urandom));
        wait_drain();
    endtask

    initial
    begin
        void'($urandom(32'h66bc));
        for (int i = 0; i < 256; i++)
            ref_table[i] = gain_t'(longint'(32768.0 * $pow(2.0, -real'(i) / 256.0)));
        rst_n        = 1'b0;
        sample_in    = '0;
        att_cmd      = '0;
        test_name    = "reset";
        model_cur    = att_t'(`EXP_ATT_MAX);
        model_target = att_t'(`EXP_ATT_MAX);
        model_rate   = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        reset_silence();
        table_sweep();
        octave_shifts();
        back_to_back_stream();
        ramp_sequence();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/exp_gain_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module exp_gain_assertions
    import audio_pkg::*, env_pkg::*;
(
    input logic           clk,
    input logic           rst_n,
    input sample_strobe_t sample_in,
    input sample_strobe_t sample_out,
    input att_cmd_t       att_cmd,
    input logic           gain_valid,
    input gain_t          gain,
    input logic           sample_d_valid,
    input att_t           att_cur,
    input att_t           target,
    input att_t           rate
);

    // fixed five cycle path
    assert property (@(posedge clk) disable iff (!rst_n)
        sample_out.valid == $past(sample_in.valid, 5))
    else $error("sample_out.valid not aligned with sample_in.valid");

    // delayed sample meets its gain at the multiplier
    assert property (@(posedge clk) disable iff (!rst_n)
        sample_d_valid == gain_valid)
    else $error("delayed sample not aligned with its gain");

    assert property (@(posedge clk) disable iff (!rst_n)
        gain_valid |-> gain <= 16'd32768)
    else $error("gain above unity");

    // a step lands on the same side of target or on it
    assert property (@(posedge clk) disable iff (!rst_n)
        (sample_in.valid && !att_cmd.valid && rate != '0)
        |=> (($past(att_cur) <= $past(target)) ? (att_cur <= $past(target))
                                               : (att_cur >= $past(target))))
    else $error("att_cur stepped past target");

endmodule

bind exp_gain_top exp_gain_assertions exp_gain_assertions_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_in      (sample_in),
    .sample_out     (sample_out),
    .att_cmd        (att_cmd),
    .gain_valid     (gain_valid),
    .gain           (gain),
    .sample_d_valid (sample_d_valid),
    .att_cur        (att_cur),
    .target         (att_ramp_inst.target_q),
    .rate           (att_ramp_inst.rate_q)
);

`default_nettype wire

// ==== hw/exp_gain_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exp_gain_defs.svh"

module exp_gain_top
    import audio_pkg::*, env_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  sample_strobe_t sample_in,
    input  att_cmd_t       att_cmd,
    output sample_strobe_t sample_out
);

    att_t           att_cur;
    logic           gain_valid;
    gain_t          gain;
    logic           sample_d_valid;
    sample_t        sample_d_data;
    sample_strobe_t sample_d;

    att_ramp att_ramp_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (att_cmd),
        .sample_tick (sample_in.valid),
        .att_cur     (att_cur)
    );

    // gain for each sample, four cycles later
    exp_shift exp_shift_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .att_valid  (sample_in.valid),
        .att        (att_cur),
        .gain_valid (gain_valid),
        .gain       (gain)
    );

    // hold the sample until its gain is ready
    pipe_delay #(
        .DEPTH     (`EXP_CONV_LAT),
        .payload_t (sample_t)
    ) sample_delay_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sample_in.valid),
        .in_data   (sample_in.data),
        .out_valid (sample_d_valid),
        .out_data  (sample_d_data)
    );

    assign sample_d = '{valid: sample_d_valid, data: sample_d_data};

    gain_mult gain_mult_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .gain_valid (gain_valid),
        .gain       (gain),
        .sample_d   (sample_d),
        .sample_out (sample_out)
    );

endmodule

`default_nettype wire

// ==== hw/gain_mult.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exp_gain_defs.svh"

module gain_mult
    import audio_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           gain_valid,
    input  gain_t          gain,
    input  sample_strobe_t sample_d,
    output sample_strobe_t sample_out
);

    localparam int PROD_W = `EXP_SAMPLE_W + `EXP_GAIN_W + 1;

    logic signed [`EXP_GAIN_W:0] gain_s;
    logic signed [PROD_W-1:0]    prod;
    logic signed [PROD_W-1:0]    prod_rnd;
    logic signed [PROD_W-1:0]    prod_scaled;
    logic                        valid_q;
    sample_t                     data_q;

    // zero extend so unity gain stays positive
    assign gain_s      = $signed({1'b0, gain});
    assign prod        = sample_d.data * gain_s;
    assign prod_rnd    = prod + PROD_W'(16384);
    assign prod_scaled = prod_rnd >>> (`EXP_GAIN_W - 1);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= gain_valid;
        end
    end

    // gain <= unity, result always fits
    always_ff @(posedge clk)
    begin
        data_q <= prod_scaled[`EXP_SAMPLE_W-1:0];
    end

    assign sample_out = '{valid: valid_q, data: data_q};

endmodule

`default_nettype wire

// ==== hw/att_ramp.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exp_gain_defs.svh"

module att_ramp
    import env_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  att_cmd_t cmd,
    input  logic     sample_tick,
    output att_t     att_cur
);

    att_t cur_q;
    att_t target_q;
    att_t rate_q;
    att_t cur_step;

    // one step toward target, clamped at target
    always_comb
    begin
        cur_step = cur_q;
        if (cur_q < target_q)
        begin
            if (target_q - cur_q <= rate_q)
            begin
                cur_step = target_q;
            end
            else
            begin
                cur_step = cur_q + rate_q;
            end
        end
        else if (cur_q > target_q)
        begin
            if (cur_q - target_q <= rate_q)
            begin
                cur_step = target_q;
            end
            else
            begin
                cur_step = cur_q - rate_q;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cur_q    <= att_t'(`EXP_ATT_MAX);
            target_q <= att_t'(`EXP_ATT_MAX);
            rate_q   <= '0;
        end
        else if (cmd.valid)
        begin
            // a command overrides a tick in the same cycle
            target_q <= cmd.target;
            rate_q   <= cmd.rate;
            if (cmd.rate == '0)
            begin
                cur_q <= cmd.target;
            end
        end
        else if (sample_tick)
        begin
            cur_q <= cur_step;
        end
    end

    // sample in this cycle sees the value before its own step
    assign att_cur = cur_q;

endmodule

`default_nettype wire

// ==== hw/exp_shift.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exp_gain_defs.svh"

module exp_shift
    import env_pkg::*, audio_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  att_valid,
    input  att_t  att,
    output logic  gain_valid,
    output gain_t gain
);

    att_split_t att_s;
    gain_t      rom_data;
    logic       shift_valid;
    att_shift_t shift_d;
    logic       gain_valid_q;
    gain_t      gain_q;

    assign att_s = att_split_t'(att);

    exp_shift_sp_rom exp_shift_sp_rom_inst (
        .clk  (clk),
        .addr (att_s.frac),
        .data (rom_data)
    );

    // octave count rides beside the table read
    pipe_delay #(
        .DEPTH     (`EXP_ROM_LAT),
        .payload_t (att_shift_t)
    ) shift_delay_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (att_valid),
        .in_data   (att_s.shift),
        .out_valid (shift_valid),
        .out_data  (shift_d)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            gain_valid_q <= 1'b0;
        end
        else
        begin
            gain_valid_q <= shift_valid;
        end
    end

    // one octave per shift position
    always_ff @(posedge clk)
    begin
        gain_q <= rom_data >> shift_d;
    end

    assign gain_valid = gain_valid_q;
    assign gain       = gain_q;

endmodule

`default_nettype wire

// ==== hw/pipe_delay.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_delay #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    logic [DEPTH-1:0] valid_q;
    payload_t         data_q [DEPTH];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q <= '0;
        end
        else
        begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++)
            begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // payload just follows the strobe
    always_ff @(posedge clk)
    begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++)
        begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== hw/exp_shift_sp_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exp_gain_defs.svh"

module exp_shift_sp_rom
    import audio_pkg::*;
(
    input  logic                   clk,
    input  logic [`EXP_FRAC_W-1:0] addr,
    output gain_t                  data
);

    localparam int ROM_DEPTH = 1 << `EXP_FRAC_W;

    gain_t                  rom [ROM_DEPTH];
    logic [`EXP_FRAC_W-1:0] addr_q;
    gain_t                  rom_q;
    gain_t                  data_q;

    // entry i = round(32768 * 2^(-i/256))
    initial
    begin
        for (int i = 0; i < ROM_DEPTH; i++)
        begin
            rom[i] = gain_t'($rtoi(32768.0 * (2.0 ** (-real'(i) / real'(ROM_DEPTH))) + 0.5));
        end
    end

    // address, table and output registers
    always_ff @(posedge clk)
    begin
        addr_q <= addr;
        rom_q  <= rom[addr_q];
        data_q <= rom_q;
    end

    assign data = data_q;

endmodule

`default_nettype wire

// ==== hw/env_pkg.sv ====
`default_nettype none

`include "exp_gain_defs.svh"

package env_pkg;

    typedef logic [`EXP_ATT_W-1:0] att_t;
    typedef logic [`EXP_SHIFT_W-1:0] att_shift_t;
    typedef logic [`EXP_FRAC_W-1:0] att_frac_t;

    // octave count on top, table index below
    typedef struct packed {
        att_shift_t shift;
        att_frac_t  frac;
    } att_split_t;

    // rate of zero jumps straight to target
    typedef struct packed {
        logic valid;
        att_t target;
        att_t rate;
    } att_cmd_t;

endpackage

`default_nettype wire

// ==== hw/audio_pkg.sv ====
`default_nettype none

`include "exp_gain_defs.svh"

package audio_pkg;

    // two's complement audio sample
    typedef logic signed [`EXP_SAMPLE_W-1:0] sample_t;

    // unsigned Q1.15, 32768 is unity
    typedef logic [`EXP_GAIN_W-1:0] gain_t;

    typedef struct packed {
        logic    valid;
        sample_t data;
    } sample_strobe_t;

endpackage

`default_nettype wire

// ==== include/exp_gain_defs.svh ====
`ifndef EXP_GAIN_DEFS_SVH
`define EXP_GAIN_DEFS_SVH

// attenuation in 1/256 octave steps
`define EXP_ATT_W 12
`define EXP_FRAC_W 8
`define EXP_SHIFT_W 4

// audio data path
`define EXP_GAIN_W 16
`define EXP_SAMPLE_W 16

// pipeline latencies in cycles
`define EXP_ROM_LAT 3
`define EXP_CONV_LAT 4

// full attenuation, gain rounds to zero
`define EXP_ATT_MAX 4095

`endif
